//--- src/int_alu_cfg.svh
`ifndef INT_ALU_CFG_SVH
`define INT_ALU_CFG_SVH

`define INT_ALU_DATA_W  64
`define INT_ALU_OP_W    13
`define INT_ALU_FLAGS_W 6

// opcode byte op[7:0], bit 0 selects the 32-bit form for add/sub and logic
`define OPC_ADD64    8'h00
`define OPC_ADD32    8'h01
`define OPC_SUB64    8'h02
`define OPC_SUB32    8'h03
`define OPC_AND64    8'h08
`define OPC_AND32    8'h09
`define OPC_OR64     8'h0a
`define OPC_OR32     8'h0b
`define OPC_XOR64    8'h0c
`define OPC_XOR32    8'h0d
`define OPC_XNOR64   8'h0e
`define OPC_XNOR32   8'h0f
`define OPC_MOV64    8'h10
`define OPC_MOV32    8'h11
`define OPC_MOV16    8'h12
`define OPC_ZXT8_64  8'h18
`define OPC_ZXT16_64 8'h19
`define OPC_SXT8_64  8'h1a
`define OPC_SXT16_64 8'h1b
`define OPC_SXT32_64 8'h1c
`define OPC_CMOV64   8'h20 // bit 0 is the condition invert
`define OPC_CSET     8'h22

// condition code is {op[10:8], op[0]}
`define COND_Z      4'd0
`define COND_NZ     4'd1
`define COND_S      4'd2
`define COND_NS     4'd3
`define COND_UGT    4'd4
`define COND_ULE    4'd5
`define COND_UGE    4'd6
`define COND_ULT    4'd7
`define COND_SGT    4'd8
`define COND_SLE    4'd9
`define COND_SGE    4'd10
`define COND_SLT    4'd11
`define COND_O      4'd12
`define COND_NO     4'd13
`define COND_P      4'd14
`define COND_ALWAYS 4'd15

`endif

//--- src/int_alu_pkg.sv
`include "int_alu_cfg.svh"

package int_alu_pkg;

  typedef enum logic [1:0] {UNIT_ADD, UNIT_LOGIC, UNIT_MOVE, UNIT_COND} unit_e;

  typedef enum logic [1:0] {FK_ARITH, FK_LOGIC, FK_NONE} flag_kind_e;

  typedef enum logic [2:0] {LF_AND, LF_OR, LF_XOR, LF_XNOR, LF_ZERO} logic_fn_e;

  typedef enum logic [3:0] {
    MK_MOV64, MK_MOV32, MK_MOV16,
    MK_ZXT8, MK_ZXT16, MK_SXT8, MK_SXT16, MK_SXT32,
    MK_CMOV, MK_CSET
  } mov_kind_e;

  typedef struct packed {
    logic       no_flags;
    logic       foreign;  // op belongs to another unit
    logic [2:0] rsv;
    logic [7:0] opcode;
  } alu_arith_view_t;

  typedef struct packed {
    logic       no_flags;
    logic       foreign;
    logic [2:0] code_hi;
    logic [6:0] opc_hi;
    logic       code_inv;
  } alu_cond_view_t;

  typedef union packed {
    alu_arith_view_t a;
    alu_cond_view_t  c;
  } alu_op_u;

  typedef struct packed {
    unit_e      unit;
    logic       is_sub;
    logic       is_32;
    logic_fn_e  lfn;
    mov_kind_e  mkind;
    logic [3:0] cond;
    flag_kind_e flag_kind;
    logic       foreign;
  } alu_ctl_t;

  typedef struct packed {
    logic [`INT_ALU_DATA_W-1:0] value;
    logic                       c;
    logic                       a;
    logic                       o;
  } exe_out_t;

  typedef struct packed {
    logic [`INT_ALU_FLAGS_W-1:0] flags; // COASZP
    logic                        sets_flags;
  } alu_ret_t;

endpackage

//--- src/alu_decode.sv
`timescale 1ns/1ps
`include "int_alu_cfg.svh"

module alu_decode import int_alu_pkg::*; (
  input  alu_op_u  op,
  output alu_ctl_t ctl
);

  logic [7:0] opc;
  logic       is_cond_op;

  assign opc = op.a.opcode;

  // cond ops ignore bit 0, that is the invert bit
  assign is_cond_op = ({op.c.opc_hi, 1'b0} == `OPC_CMOV64) ||
                      ({op.c.opc_hi, 1'b0} == `OPC_CSET);

  always_comb begin
    ctl           = '0;
    ctl.unit      = UNIT_LOGIC;
    ctl.lfn       = LF_ZERO;    // unknown opcode gives zero
    ctl.flag_kind = FK_NONE;
    ctl.cond      = {op.c.code_hi, op.c.code_inv};
    ctl.foreign   = op.a.foreign;

    case (opc)
      `OPC_MOV32:    ctl.mkind = MK_MOV32;
      `OPC_MOV16:    ctl.mkind = MK_MOV16;
      `OPC_ZXT8_64:  ctl.mkind = MK_ZXT8;
      `OPC_ZXT16_64: ctl.mkind = MK_ZXT16;
      `OPC_SXT8_64:  ctl.mkind = MK_SXT8;
      `OPC_SXT16_64: ctl.mkind = MK_SXT16;
      `OPC_SXT32_64: ctl.mkind = MK_SXT32;
      default:       ctl.mkind = MK_MOV64;
    endcase

    case (opc)
      `OPC_ADD64, `OPC_ADD32, `OPC_SUB64, `OPC_SUB32: begin
        ctl.unit      = UNIT_ADD;
        ctl.is_sub    = opc[1];
        ctl.is_32     = opc[0];
        ctl.flag_kind = FK_ARITH;
      end
      `OPC_AND64, `OPC_AND32, `OPC_OR64, `OPC_OR32,
      `OPC_XOR64, `OPC_XOR32, `OPC_XNOR64, `OPC_XNOR32: begin
        ctl.lfn       = logic_fn_e'({1'b0, opc[2:1]});
        ctl.is_32     = opc[0];
        ctl.flag_kind = FK_LOGIC;
      end
      `OPC_MOV64, `OPC_MOV32, `OPC_MOV16, `OPC_ZXT8_64, `OPC_ZXT16_64,
      `OPC_SXT8_64, `OPC_SXT16_64, `OPC_SXT32_64: begin
        ctl.unit = UNIT_MOVE;
      end
      default: ;
    endcase

    if (is_cond_op) begin
      ctl.unit  = UNIT_COND;
      ctl.mkind = ({op.c.opc_hi, 1'b0} == `OPC_CSET) ? MK_CSET : MK_CMOV;
    end

    if (op.a.no_flags) begin
      ctl.flag_kind = FK_NONE;
    end
  end

endmodule

//--- src/cond_eval.sv
`timescale 1ns/1ps
`include "int_alu_cfg.svh"

module cond_eval (
  input  logic [`INT_ALU_FLAGS_W-1:0] flags,
  input  logic [3:0]                  code,
  output logic                        take
);

  logic c;
  logic o;
  logic s;
  logic z;
  logic p;

  // COASZP order with aux carry never tested
  assign c = flags[5];
  assign o = flags[4];
  assign s = flags[2];
  assign z = flags[1];
  assign p = flags[0];

  // c is a borrow after sub
  always_comb begin
    case (code)
      `COND_Z:   take = z;
      `COND_NZ:  take = ~z;
      `COND_S:   take = s;
      `COND_NS:  take = ~s;
      `COND_UGT: take = ~c & ~z;
      `COND_ULE: take = c | z;
      `COND_UGE: take = ~c;
      `COND_ULT: take = c;
      `COND_SGT: take = ~((s ^ o) | z);
      `COND_SLE: take = (s ^ o) | z;
      `COND_SGE: take = ~(s ^ o);
      `COND_SLT: take = s ^ o;
      `COND_O:   take = o;
      `COND_NO:  take = ~o;
      `COND_P:   take = p;
      default:   take = 1'b1; // always
    endcase
  end

endmodule

//--- src/alu_execute.sv
`timescale 1ns/1ps
`include "int_alu_cfg.svh"

module alu_execute import int_alu_pkg::*; (
  input  alu_ctl_t                   ctl,
  input  logic [`INT_ALU_DATA_W-1:0] val1,
  input  logic [`INT_ALU_DATA_W-1:0] val2,
  input  logic                       take,
  output exe_out_t                   exe
);

  localparam int W = `INT_ALU_DATA_W;
  localparam int H = W / 2;

  logic [W-1:0] opb;
  logic [W:0]   sum;
  logic         carry;
  logic         aux;
  logic         msb_a;
  logic         msb_b;
  logic         msb_s;
  logic [W-1:0] add_val;
  logic [W-1:0] logic_val;
  logic [W-1:0] move_val;
  logic [W-1:0] cond_val;

  // sub is a + ~b + 1
  assign opb = ctl.is_sub ? ~val2 : val2;
  assign sum = {1'b0, val1} + {1'b0, opb} + {{W{1'b0}}, ctl.is_sub};

  // carry into bit 32 recovered from the sum bit
  assign carry = ctl.is_32 ? (sum[H] ^ val1[H] ^ opb[H]) : sum[W];
  assign aux   = sum[4] ^ val1[4] ^ opb[4];

  assign msb_a = ctl.is_32 ? val1[H-1] : val1[W-1];
  assign msb_b = ctl.is_32 ? opb[H-1] : opb[W-1];
  assign msb_s = ctl.is_32 ? sum[H-1] : sum[W-1];

  assign add_val = ctl.is_32 ? {{H{1'b0}}, sum[H-1:0]} : sum[W-1:0];

  always_comb begin
    case (ctl.lfn)
      LF_AND:  logic_val = val1 & val2;
      LF_OR:   logic_val = val1 | val2;
      LF_XOR:  logic_val = val1 ^ val2;
      LF_XNOR: logic_val = ~(val1 ^ val2);
      default: logic_val = '0;
    endcase
    if (ctl.is_32) begin
      logic_val[W-1:H] = '0;
    end
  end

  always_comb begin
    case (ctl.mkind)
      MK_MOV32: move_val = {{H{1'b0}}, val2[H-1:0]};
      MK_MOV16: move_val = {val1[W-1:16], val2[15:0]}; // merges into val1
      MK_ZXT8:  move_val = {{(W-8){1'b0}}, val2[7:0]};
      MK_ZXT16: move_val = {{(W-16){1'b0}}, val2[15:0]};
      MK_SXT8:  move_val = {{(W-8){val2[7]}}, val2[7:0]};
      MK_SXT16: move_val = {{(W-16){val2[15]}}, val2[15:0]};
      MK_SXT32: move_val = {{H{val2[H-1]}}, val2[H-1:0]};
      default:  move_val = val2;
    endcase
  end

  assign cond_val = (ctl.mkind == MK_CSET) ? {{(W-1){1'b0}}, take} :
                    (take ? val2 : val1);

  always_comb begin
    exe = '0;
    case (ctl.unit)
      UNIT_ADD: begin
        exe.value = add_val;
        exe.c     = carry ^ ctl.is_sub; // borrow on sub
        exe.a     = aux ^ ctl.is_sub;
        exe.o     = (msb_a == msb_b) && (msb_s != msb_a);
      end
      UNIT_LOGIC: exe.value = logic_val;
      UNIT_MOVE:  exe.value = move_val;
      default:    exe.value = cond_val;
    endcase
  end

endmodule

//--- src/flag_result.sv
`timescale 1ns/1ps
`include "int_alu_cfg.svh"

module flag_result import int_alu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  alu_ctl_t                   ctl,
  input  exe_out_t                   exe,
  input  logic                       data_en,
  input  logic                       thread,
  input  logic                       except,
  input  logic                       except_thread,
  output logic [`INT_ALU_DATA_W-1:0] result,
  output alu_ret_t                   ret,
  output logic                       ret_en
);

  localparam int W = `INT_ALU_DATA_W;
  localparam int H = W / 2;

  logic [W-1:0] res_q;
  flag_kind_e   kind_q;
  logic         c_q;
  logic         a_q;
  logic         o_q;
  logic         is32_q;
  logic         ret_q;
  logic         exc_q;
  logic         exc_thread_q;
  logic         inhibit;
  logic         s_flag;
  logic         z_flag;

  // same thread excepted now or one cycle back
  assign inhibit = (except && (except_thread == thread)) ||
                   (exc_q && (exc_thread_q == thread));

  always_ff @(posedge clk) begin
    if (rst) begin
      res_q        <= '0;
      kind_q       <= FK_NONE;
      ret_q        <= 1'b0;
      exc_q        <= 1'b0;
      exc_thread_q <= 1'b0;
    end else begin
      ret_q        <= data_en && !ctl.foreign && !inhibit;
      exc_q        <= except;
      exc_thread_q <= except_thread;
      if (data_en) begin
        res_q  <= exe.value;
        kind_q <= ctl.flag_kind;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (data_en) begin
      c_q    <= exe.c;
      a_q    <= exe.a;
      o_q    <= exe.o;
      is32_q <= ctl.is_32;
    end
  end

  assign s_flag = is32_q ? res_q[H-1] : res_q[W-1];
  assign z_flag = is32_q ? (res_q[H-1:0] == '0) : (res_q == '0);

  always_comb begin
    case (kind_q)
      FK_ARITH: ret.flags = {c_q, o_q, a_q, s_flag, z_flag, 1'b0}; // no parity
      FK_LOGIC: ret.flags = {3'b000, s_flag, z_flag, 1'b0};
      default:  ret.flags = '0;
    endcase
    ret.sets_flags = (kind_q != FK_NONE);
  end

  assign result = res_q;
  assign ret_en = ret_q;

  a_ret_en_after_rst: assert property (@(posedge clk) rst |=> !ret_en);

  a_ret_en_from_issue: assert property (
    @(posedge clk) disable iff (rst) ret_en |-> $past(data_en)
  );

endmodule

//--- src/int_alu.sv
`timescale 1ns/1ps
`include "int_alu_cfg.svh"

module int_alu import int_alu_pkg::*; (
  input  logic                        clk,
  input  logic                        rst,
  input  alu_op_u                     op,
  input  logic [`INT_ALU_DATA_W-1:0]  val1,
  input  logic [`INT_ALU_DATA_W-1:0]  val2,
  input  logic [`INT_ALU_FLAGS_W-1:0] flags_in,
  input  logic                        data_en,
  input  logic                        thread,
  input  logic                        except,
  input  logic                        except_thread,
  output logic [`INT_ALU_DATA_W-1:0]  result,
  output alu_ret_t                    ret,
  output logic                        ret_en
);

  alu_ctl_t ctl;
  logic     take;
  exe_out_t exe;

  alu_decode alu_decode_i (.op(op), .ctl(ctl));

  cond_eval cond_eval_i (.flags(flags_in), .code(ctl.cond), .take(take));

  alu_execute alu_execute_i (
    .ctl(ctl), .val1(val1), .val2(val2), .take(take), .exe(exe)
  );

  flag_result flag_result_i (
    .clk(clk), .rst(rst), .ctl(ctl), .exe(exe),
    .data_en(data_en), .thread(thread), .except(except),
    .except_thread(except_thread),
    .result(result), .ret(ret), .ret_en(ret_en)
  );

  // an issued op must decode to a real unit
  a_unit_known: assert property (
    @(posedge clk) disable iff (rst) data_en |-> !$isunknown(ctl.unit)
  );

endmodule

//--- dv/int_alu_checker.sv
`timescale 1ns/1ps
`include "int_alu_cfg.svh"

module int_alu_checker import int_alu_pkg::*; (
  input  logic                        clk,
  input  logic                        rst,
  input  alu_op_u                     op,
  input  logic [`INT_ALU_DATA_W-1:0]  val1,
  input  logic [`INT_ALU_DATA_W-1:0]  val2,
  input  logic [`INT_ALU_FLAGS_W-1:0] flags_in,
  input  logic                        data_en,
  input  logic                        thread,
  input  logic                        except,
  input  logic                        except_thread,
  input  logic [`INT_ALU_DATA_W-1:0]  result,
  input  alu_ret_t                    ret,
  input  logic                        ret_en,
  output int                          mismatches,
  output int                          checks,
  output logic                        busy
);

  typedef struct packed {
    logic [63:0] value;
    logic [5:0]  flags; // COASZP
    logic        sets_flags;
  } expect_t;

  expect_t exp_q;
  logic    exp_en_q;
  logic    exc_q;
  logic    exc_thread_q;
  logic    armed = 1'b0;
  logic    busy_q = 1'b0;
  int      err_cnt = 0;
  int      chk_cnt = 0;

  assign mismatches = err_cnt;
  assign checks     = chk_cnt;
  assign busy       = busy_q;

  // condition table on COASZP, carry flag means borrow
  function automatic logic cond_take(input logic [5:0] f, input logic [3:0] code);
    case (code)
      `COND_Z:   return f[1];
      `COND_NZ:  return !f[1];
      `COND_S:   return f[2];
      `COND_NS:  return !f[2];
      `COND_UGT: return !f[5] && !f[1];
      `COND_ULE: return f[5] || f[1];
      `COND_UGE: return !f[5];
      `COND_ULT: return f[5];
      `COND_SGT: return !f[1] && (f[2] == f[4]);
      `COND_SLE: return f[1] || (f[2] != f[4]);
      `COND_SGE: return f[2] == f[4];
      `COND_SLT: return f[2] != f[4];
      `COND_O:   return f[4];
      `COND_NO:  return !f[4];
      `COND_P:   return f[0];
      default:   return 1'b1;
    endcase
  endfunction

  function automatic expect_t ref_model(input alu_op_u w, input logic [63:0] a,
                                        input logic [63:0] b, input logic [5:0] f);
    expect_t     e;
    flag_kind_e  kind;
    logic [7:0]  opc;
    logic [3:0]  code;
    logic [64:0] xa;
    logic [64:0] xb;
    logic [64:0] wide;
    logic [4:0]  nib;
    logic        sub;
    logic        half;
    logic        sa;
    logic        sb;
    logic        sr;
    logic        cy;
    logic        ov;
    e = '0;
    kind = FK_NONE;
    opc = w.a.opcode;
    code = {w.c.code_hi, w.c.code_inv};
    sub = opc[1];
    half = opc[0];
    case (opc)
      `OPC_ADD64, `OPC_ADD32, `OPC_SUB64, `OPC_SUB32: begin
        kind = FK_ARITH;
        xa = half ? {33'd0, a[31:0]} : {1'b0, a};
        xb = half ? {33'd0, b[31:0]} : {1'b0, b};
        wide = sub ? xa - xb : xa + xb; // wraps on borrow
        nib = sub ? {1'b0, a[3:0]} - {1'b0, b[3:0]} : {1'b0, a[3:0]} + {1'b0, b[3:0]};
        e.value = half ? {32'd0, wide[31:0]} : wide[63:0];
        cy = half ? wide[32] : wide[64];
        sa = half ? a[31] : a[63];
        sb = half ? b[31] : b[63];
        sr = half ? wide[31] : wide[63];
        ov = sub ? (sa != sb && sr != sa) : (sa == sb && sr != sa);
        e.flags = {cy, ov, nib[4], sr, e.value == 0, 1'b0};
      end
      `OPC_AND64, `OPC_AND32, `OPC_OR64, `OPC_OR32,
      `OPC_XOR64, `OPC_XOR32, `OPC_XNOR64, `OPC_XNOR32: begin
        kind = FK_LOGIC;
        case (opc)
          `OPC_AND64, `OPC_AND32: e.value = a & b;
          `OPC_OR64, `OPC_OR32:   e.value = a | b;
          `OPC_XOR64, `OPC_XOR32: e.value = a ^ b;
          default:                e.value = ~(a ^ b);
        endcase
        if (half) begin
          e.value[63:32] = '0;
        end
        e.flags = {3'b000, e.value[half ? 31 : 63], e.value == 0, 1'b0};
      end
      `OPC_MOV64:    e.value = b;
      `OPC_MOV32:    e.value = {32'd0, b[31:0]};
      `OPC_MOV16:    e.value = {a[63:16], b[15:0]}; // low 16 bits replaced
      `OPC_ZXT8_64:  e.value = {56'd0, b[7:0]};
      `OPC_ZXT16_64: e.value = {48'd0, b[15:0]};
      `OPC_SXT8_64:  e.value = {{56{b[7]}}, b[7:0]};
      `OPC_SXT16_64: e.value = {{48{b[15]}}, b[15:0]};
      `OPC_SXT32_64: e.value = {{32{b[31]}}, b[31:0]};
      default: begin
        if ({opc[7:1], 1'b0} == `OPC_CMOV64) begin
          e.value = cond_take(f, code) ? b : a;
        end else if ({opc[7:1], 1'b0} == `OPC_CSET) begin
          e.value = {63'd0, cond_take(f, code)};
        end
      end
    endcase
    e.sets_flags = (kind != FK_NONE) && !w.a.no_flags;
    if (!e.sets_flags) begin
      e.flags = '0;
    end
    return e;
  endfunction

  task automatic compare(input string name, input logic [63:0] want, input logic [63:0] got);
    chk_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, want, got);
    end
  endtask

  // outputs now belong to the inputs of the previous edge
  always @(posedge clk) begin
    if (armed) begin
      compare("result", exp_q.value, result);
      compare("ret.flags", exp_q.flags, ret.flags);
      compare("ret.sets_flags", exp_q.sets_flags, ret.sets_flags);
      compare("ret_en", exp_en_q, ret_en);
    end
    if (rst) begin
      armed        <= 1'b1;
      exp_q        <= '0;
      exp_en_q     <= 1'b0;
      exc_q        <= 1'b0;
      exc_thread_q <= 1'b0;
      busy_q       <= 1'b0;
    end else begin
      if (data_en) begin
        exp_q <= ref_model(op, val1, val2, flags_in); // output register holds otherwise
      end
      exp_en_q <= data_en && !op.a.foreign && !(except && except_thread == thread) &&
                  !(exc_q && exc_thread_q == thread);
      exc_q        <= except;
      exc_thread_q <= except_thread;
      busy_q       <= data_en;
    end
  end

endmodule

//--- dv/int_alu_tb.sv
`timescale 1ns/1ps
`include "int_alu_cfg.svh"

module int_alu_tb import int_alu_pkg::*; ();

  logic                        clk;
  logic                        rst;
  alu_op_u                     op;
  logic [`INT_ALU_DATA_W-1:0]  val1;
  logic [`INT_ALU_DATA_W-1:0]  val2;
  logic [`INT_ALU_FLAGS_W-1:0] flags_in;
  logic                        data_en;
  logic                        thread;
  logic                        except;
  logic                        except_thread;
  logic [`INT_ALU_DATA_W-1:0]  result;
  alu_ret_t                    ret;
  logic                        ret_en;
  int                          mismatches;
  int                          checks;
  logic                        busy;
  logic [63:0]                 rng;
  int                          tb_errors;
  int                          err_base;
  int                          n_tests;

  logic [7:0] arith_ops [4] = '{`OPC_ADD64, `OPC_ADD32, `OPC_SUB64, `OPC_SUB32};
  logic [7:0] logic_ops [8] = '{`OPC_AND64, `OPC_AND32, `OPC_OR64, `OPC_OR32,
                                `OPC_XOR64, `OPC_XOR32, `OPC_XNOR64, `OPC_XNOR32};
  logic [7:0] move_ops [8]  = '{`OPC_MOV64, `OPC_MOV32, `OPC_MOV16, `OPC_ZXT8_64,
                                `OPC_ZXT16_64, `OPC_SXT8_64, `OPC_SXT16_64, `OPC_SXT32_64};

  int_alu int_alu_i (.*);

  int_alu_checker checker_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [63:0] xorshift(input logic [63:0] x);
    logic [63:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 7);
    return s ^ (s << 17);
  endfunction

  function automatic logic [12:0] arith_word(input logic [7:0] opc, input logic nf = 1'b0,
                                             input logic fr = 1'b0);
    return {nf, fr, 3'b000, opc};
  endfunction

  // condition code splits over op[10:8] and op[0]
  function automatic logic [12:0] cond_word(input logic [7:0] base, input logic [3:0] code);
    return {2'b00, code[3:1], base[7:1], code[0]};
  endfunction

  task automatic send(input logic [12:0] w, input logic [63:0] a, input logic [63:0] b,
                      input logic [5:0] f = '0, input logic en = 1'b1,
                      input logic thr = 1'b0, input logic exc = 1'b0,
                      input logic exc_thr = 1'b0);
    @(negedge clk);
    op            = w;
    val1          = a;
    val2          = b;
    flags_in      = f;
    data_en       = en;
    thread        = thr;
    except        = exc;
    except_thread = exc_thr;
  endtask

  task automatic send_rand(input logic [7:0] opc, input logic allow_nf);
    logic [63:0] a;
    logic [63:0] b;
    rng = xorshift(rng);
    a = rng;
    rng = xorshift(rng);
    b = rng;
    rng = xorshift(rng);
    if (rng[9:8] == 2'b00) begin
      b = a; // equal operands give zero results
    end
    send(arith_word(opc, allow_nf & rng[7]), a, b, rng[5:0]);
  endtask

  task automatic finish_test(input string name);
    int n;
    n = 0;
    send('0, '0, '0, '0, 1'b0);
    while (busy && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      tb_errors++;
      $display("%s: last result was never compared within 20 cycles", name);
    end
    n_tests++;
    $display("test %s done, %0d errors", name, mismatches + tb_errors - err_base);
    err_base = mismatches + tb_errors;
  endtask

  initial begin
    int i;
    int cnt;
    rst = 1'b1;
    op = '0;
    val1 = '0;
    val2 = '0;
    flags_in = '0;
    data_en = 1'b0;
    thread = 1'b0;
    except = 1'b0;
    except_thread = 1'b0;
    rng = 64'd89;
    tb_errors = 0;
    err_base = 0;
    n_tests = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // live operands with data_en low must leave the outputs at zero
    for (i = 0; i < 3; i++) begin
      send(arith_word(`OPC_SUB64), 64'd1, 64'd2 + i, '0, 1'b0);
    end
    send(arith_word(`OPC_ADD64), 64'd5, 64'd7);
    cnt = 0;
    while (!ret_en && cnt < 10) begin
      @(negedge clk);
      data_en = 1'b0;
      cnt++;
    end
    if (cnt != 1) begin
      tb_errors++;
      $display("ret_en came %0d cycles after data_en instead of 1", cnt);
    end
    finish_test("reset");

    send(arith_word(`OPC_ADD64), '1, 64'd1);                 // carry out
    send(arith_word(`OPC_SUB64), 64'd0, 64'd1);              // borrow
    send(arith_word(`OPC_ADD64), 64'h7fff_ffff_ffff_ffff, 64'd1);
    send(arith_word(`OPC_ADD32), 64'hffff_ffff_7fff_ffff, 64'd1);
    send(arith_word(`OPC_SUB32), 64'h8000_0000, 64'd1);
    send(arith_word(`OPC_ADD32), 64'hffff_ffff, 64'd1);
    send(arith_word(`OPC_SUB64), 64'h10, 64'd1);              // aux borrow
    for (i = 0; i < 48; i++) begin
      send_rand(arith_ops[i % 4], 1'b1);
    end
    finish_test("add_sub");

    send(arith_word(`OPC_XOR64, 1'b1), 64'h8, 64'h8);
    for (i = 0; i < 32; i++) begin
      send_rand(logic_ops[i % 8], 1'b1);
    end
    finish_test("logic");

    for (i = 0; i < 32; i++) begin
      send_rand(move_ops[i % 8], 1'b0);
    end
    finish_test("move_extend");

    for (i = 0; i < 128; i++) begin
      rng = xorshift(rng);
      send(cond_word(i[0] ? `OPC_CSET : `OPC_CMOV64, i[4:1]), rng, ~rng, rng[13:8]);
    end
    finish_test("cond");

    send(arith_word(`OPC_ADD64, 1'b0, 1'b1), 64'd1, 64'd2);  // foreign
    send(arith_word(`OPC_ADD64), 64'd3, 64'd4, '0, 1'b1, 1'b0, 1'b1, 1'b0);
    send('0, '0, '0, '0, 1'b0, 1'b0, 1'b1, 1'b1);
    send(arith_word(`OPC_ADD64), 64'd5, 64'd6, '0, 1'b1, 1'b1);
    send(arith_word(`OPC_ADD64), 64'd7, 64'd8, '0, 1'b1, 1'b0, 1'b1, 1'b1);
    send(arith_word(`OPC_ADD64), 64'd9, 64'd10);
    for (i = 0; i < 8; i++) begin
      send_rand(arith_ops[i % 4], 1'b0);
    end
    finish_test("ret_en");

    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, checks,
             mismatches + tb_errors);
    if (mismatches + tb_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- int_alu.f
+incdir+src
src/int_alu_pkg.sv
src/alu_decode.sv
src/cond_eval.sv
src/alu_execute.sv
src/flag_result.sv
src/int_alu.sv
dv/int_alu_checker.sv
dv/int_alu_tb.sv

//--- Bender.yml
package:
  name: int_alu

sources:
  - include_dirs:
      - src
    files:
      - src/int_alu_pkg.sv
      - src/alu_decode.sv
      - src/cond_eval.sv
      - src/alu_execute.sv
      - src/flag_result.sv
      - src/int_alu.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/int_alu_checker.sv
      - dv/int_alu_tb.sv
